//--- source/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////

// Register and address width
`define MEM_XLEN        32

// Byte-wide memory bus
`define MEM_BYTE_W      8

// Destination register index
`define MEM_REG_ADDR_W  5

// Bytes per word, also the most reads in flight
`define MEM_MAX_BYTES   4

`endif

//--- source/mem_op_pkg.sv
`include "mem_cfg.svh"

package mem_op_pkg;

    typedef logic [`MEM_XLEN-1:0] word_t;

    typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        MEM_ALU   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // Index of the last byte touched by an access of this size
    function automatic logic [$clog2(`MEM_MAX_BYTES)-1:0] last_byte_idx(mem_size_t size);
        case (size)
            SIZE_BYTE: return 'd0;
            SIZE_HALF: return 'd1;
            default:   return 'd3;
        endcase
    endfunction

endpackage

//--- source/mem_bus_pkg.sv
`include "mem_cfg.svh"

package mem_bus_pkg;

    ////////////////////////////////////////////////////
    // Byte-wide memory controller bus
    ////////////////////////////////////////////////////

    typedef logic [`MEM_XLEN-1:0] bus_addr_t;

    typedef logic [`MEM_BYTE_W-1:0] byte_t;

    // Byte position inside a word
    typedef logic [$clog2(`MEM_MAX_BYTES)-1:0] byte_idx_t;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_cmd_t;

endpackage

//--- source/mem_access_seq.sv
`timescale 1ns/10ps

`include "mem_cfg.svh"

module mem_access_seq
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // Operation from execute
    input  logic      op_valid_i,
    input  mem_kind_t op_kind_i,
    input  mem_size_t op_size_i,
    input  logic      op_signed_i,
    input  word_t     op_addr_i,
    input  word_t     op_wdata_i,
    input  reg_addr_t op_rd_i,
    input  logic      op_we_i,
    output logic      op_ready_o,

    // Byte requests to the memory controller
    output logic      mem_req_valid_o,
    output bus_cmd_t  mem_req_cmd_o,
    output bus_addr_t mem_req_addr_o,
    output byte_t     mem_req_wdata_o,
    input  logic      mem_req_ready_i,

    // Result builder link
    input  logic      wb_done_i,
    output logic      start_o,
    output mem_kind_t start_kind_o,
    output mem_size_t start_size_o,
    output logic      start_signed_o,
    output reg_addr_t start_rd_o,
    output word_t     start_value_o
);

    logic      busy_q;
    logic      req_active_q;
    byte_idx_t req_idx_q;
    mem_kind_t kind_q;
    mem_size_t size_q;
    bus_addr_t base_q;
    word_t     wdata_q;

    logic      op_accept;
    logic      req_fire;
    logic      req_last;
    logic      needs_wb;

    ////////////////////////////////////////////////////
    // Operation acceptance
    ////////////////////////////////////////////////////

    assign op_ready_o = ~busy_q;
    assign op_accept  = op_valid_i & op_ready_o;

    // Loads always return data, ALU ops only when rd is written
    assign needs_wb = (op_kind_i == MEM_LOAD) | ((op_kind_i == MEM_ALU) & op_we_i);

    assign start_o        = op_accept & needs_wb;
    assign start_kind_o   = op_kind_i;
    assign start_size_o   = op_size_i;
    assign start_signed_o = op_signed_i;
    assign start_rd_o     = op_rd_i;
    assign start_value_o  = op_addr_i;

    ////////////////////////////////////////////////////
    // Byte request issue
    ////////////////////////////////////////////////////

    assign req_fire = req_active_q & mem_req_ready_i;
    assign req_last = (req_idx_q == last_byte_idx(size_q));

    assign mem_req_valid_o = req_active_q;
    assign mem_req_cmd_o   = (kind_q == MEM_STORE) ? BUS_WRITE : BUS_READ;
    assign mem_req_addr_o  = base_q + bus_addr_t'(req_idx_q);

    // Lowest byte goes out first
    assign mem_req_wdata_o = wdata_q[req_idx_q*`MEM_BYTE_W +: `MEM_BYTE_W];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            req_active_q <= 1'b0;
            req_idx_q    <= '0;
            kind_q       <= MEM_ALU;
            size_q       <= SIZE_BYTE;
        end else begin
            if (op_accept) begin
                kind_q <= op_kind_i;
                size_q <= op_size_i;
                if (op_kind_i != MEM_ALU) begin
                    busy_q       <= 1'b1;
                    req_active_q <= 1'b1;
                    req_idx_q    <= '0;
                end else if (op_we_i) begin
                    busy_q <= 1'b1;
                end
            end else if (req_fire) begin
                if (req_last) begin
                    req_active_q <= 1'b0;
                    // Stores finish once the last byte is taken
                    if (kind_q == MEM_STORE) begin
                        busy_q <= 1'b0;
                    end
                end else begin
                    req_idx_q <= req_idx_q + 1'b1;
                end
            end

            if (wb_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Address base and store data of the current access
    always_ff @(posedge clk) begin
        if (op_accept) begin
            base_q  <= op_addr_i;
            wdata_q <= op_wdata_i;
        end
    end

endmodule

//--- source/wb_result_builder.sv
`timescale 1ns/10ps

`include "mem_cfg.svh"

module wb_result_builder
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // Operation start from the sequencer
    input  logic      start_i,
    input  mem_kind_t start_kind_i,
    input  mem_size_t start_size_i,
    input  logic      start_signed_i,
    input  reg_addr_t start_rd_i,
    input  word_t     start_value_i,

    // Read responses, in request order
    input  logic      mem_resp_valid_i,
    input  byte_t     mem_resp_data_i,

    // Writeback
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    input  logic      wb_ready_i,
    output logic      wb_done_o
);

    logic      collect_q;
    logic      wb_valid_q;
    byte_idx_t resp_idx_q;
    mem_size_t size_q;
    logic      signed_q;
    reg_addr_t rd_q;
    word_t     data_q;
    byte_t     lanes_q [`MEM_MAX_BYTES];

    word_t     assembled;
    logic      resp_take;
    logic      resp_last;

    // Sign fill comes from the top loaded byte only
    function automatic word_t extend_load(word_t raw, mem_size_t size, logic sgn);
        logic fill_b;
        logic fill_h;
        fill_b = sgn & raw[`MEM_BYTE_W-1];
        fill_h = sgn & raw[2*`MEM_BYTE_W-1];
        case (size)
            SIZE_BYTE: return {{(`MEM_XLEN-`MEM_BYTE_W){fill_b}}, raw[`MEM_BYTE_W-1:0]};
            SIZE_HALF: return {{(`MEM_XLEN-2*`MEM_BYTE_W){fill_h}}, raw[2*`MEM_BYTE_W-1:0]};
            default:   return raw;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // Little-endian byte assembly
    ////////////////////////////////////////////////////

    assign resp_take = collect_q & mem_resp_valid_i;
    assign resp_last = (resp_idx_q == last_byte_idx(size_q));

    // Current response merged with the bytes already held
    always_comb begin
        for (int i = 0; i < `MEM_MAX_BYTES; i++) begin
            if (byte_idx_t'(i) == resp_idx_q) begin
                assembled[i*`MEM_BYTE_W +: `MEM_BYTE_W] = mem_resp_data_i;
            end else begin
                assembled[i*`MEM_BYTE_W +: `MEM_BYTE_W] = lanes_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_take) begin
            lanes_q[resp_idx_q] <= mem_resp_data_i;
        end
    end

    ////////////////////////////////////////////////////
    // Result register and writeback handshake
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collect_q  <= 1'b0;
            wb_valid_q <= 1'b0;
            resp_idx_q <= '0;
            size_q     <= SIZE_BYTE;
            signed_q   <= 1'b0;
        end else begin
            if (start_i) begin
                if (start_kind_i == MEM_LOAD) begin
                    collect_q  <= 1'b1;
                    resp_idx_q <= '0;
                    size_q     <= start_size_i;
                    signed_q   <= start_signed_i;
                end else begin
                    wb_valid_q <= 1'b1;
                end
            end else if (resp_take) begin
                if (resp_last) begin
                    collect_q  <= 1'b0;
                    wb_valid_q <= 1'b1;
                end else begin
                    resp_idx_q <= resp_idx_q + 1'b1;
                end
            end else if (wb_done_o) begin
                wb_valid_q <= 1'b0;
            end
        end
    end

    // Held stable until the writeback is taken
    always_ff @(posedge clk) begin
        if (start_i) begin
            rd_q <= start_rd_i;
            if (start_kind_i != MEM_LOAD) begin
                data_q <= start_value_i;
            end
        end else if (resp_take && resp_last) begin
            data_q <= extend_load(assembled, size_q, signed_q);
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = data_q;
    assign wb_done_o  = wb_valid_q & wb_ready_i;

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // Operation from execute
    input  logic      op_valid_i,
    input  mem_kind_t op_kind_i,
    input  mem_size_t op_size_i,
    input  logic      op_signed_i,
    input  word_t     op_addr_i,
    input  word_t     op_wdata_i,
    input  reg_addr_t op_rd_i,
    input  logic      op_we_i,
    output logic      op_ready_o,

    // Memory controller
    output logic      mem_req_valid_o,
    output bus_cmd_t  mem_req_cmd_o,
    output bus_addr_t mem_req_addr_o,
    output byte_t     mem_req_wdata_o,
    input  logic      mem_req_ready_i,
    input  logic      mem_resp_valid_i,
    input  byte_t     mem_resp_data_i,

    // Writeback
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    input  logic      wb_ready_i
);

    logic      start;
    mem_kind_t start_kind;
    mem_size_t start_size;
    logic      start_signed;
    reg_addr_t start_rd;
    word_t     start_value;
    logic      wb_done;

    mem_access_seq u_seq (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .op_valid_i      (op_valid_i),
        .op_kind_i       (op_kind_i),
        .op_size_i       (op_size_i),
        .op_signed_i     (op_signed_i),
        .op_addr_i       (op_addr_i),
        .op_wdata_i      (op_wdata_i),
        .op_rd_i         (op_rd_i),
        .op_we_i         (op_we_i),
        .op_ready_o      (op_ready_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_cmd_o   (mem_req_cmd_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_req_ready_i (mem_req_ready_i),
        .wb_done_i       (wb_done),
        .start_o         (start),
        .start_kind_o    (start_kind),
        .start_size_o    (start_size),
        .start_signed_o  (start_signed),
        .start_rd_o      (start_rd),
        .start_value_o   (start_value)
    );

    wb_result_builder u_builder (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .start_i          (start),
        .start_kind_i     (start_kind),
        .start_size_i     (start_size),
        .start_signed_i   (start_signed),
        .start_rd_i       (start_rd),
        .start_value_i    (start_value),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .wb_ready_i       (wb_ready_i),
        .wb_done_o        (wb_done)
    );

endmodule

//--- sim/byte_mem_model.sv
`timescale 1ns/10ps

module byte_mem_model
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      req_valid_i,
    input  bus_cmd_t  req_cmd_i,
    input  bus_addr_t req_addr_i,
    input  byte_t     req_wdata_i,
    output logic      req_ready_o,
    output logic      resp_valid_o,
    output byte_t     resp_data_o
);

    byte_t mem [256];
    byte_t resp_q [$];
    int    due_q [$];
    int    seed;
    int    now;
    int    last_due;

    initial begin
        seed = 42818;
        for (int i = 0; i < 256; i++) begin
            mem[i] = byte_t'($random(seed));
        end
        req_ready_o  = 1'b0;
        resp_valid_o = 1'b0;
        resp_data_o  = '0;
        now          = 0;
        last_due     = 0;
    end

    // Request valid is a register output, so it is stable here
    always @(negedge clk) begin
        int delay;
        now++;
        req_ready_o = (($random(seed) & 3) != 0);
        if (req_valid_i && req_ready_o) begin
            if (req_cmd_i == BUS_WRITE) begin
                mem[req_addr_i[7:0]] = req_wdata_i;
            end else begin
                delay    = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                // Keep responses in order, one per cycle
                last_due = (now + delay > last_due) ? now + delay : last_due + 1;
                resp_q.push_back(mem[req_addr_i[7:0]]);
                due_q.push_back(last_due);
            end
        end

        if (due_q.size() > 0 && due_q[0] <= now) begin
            resp_valid_o = 1'b1;
            resp_data_o  = resp_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            resp_valid_o = 1'b0;
        end
    end

endmodule

//--- sim/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
;

    localparam int NROWS       = 17;
    localparam int CYCLE_LIMIT = 20 * NROWS * 12;

    // Expected-value modes
    localparam logic [1:0] M_ALU  = 2'd0;
    localparam logic [1:0] M_LOAD = 2'd1;
    localparam logic [1:0] M_NONE = 2'd2;

    typedef struct packed {
        mem_kind_t  kind;
        mem_size_t  size;
        logic       sgn;
        word_t      addr;
        word_t      wdata;
        reg_addr_t  rd;
        logic       we;
        logic [1:0] mode;
        logic [3:0] hold;
    } op_row_t;

    logic      clk;
    logic      rst_n_i;
    logic      op_valid_i;
    mem_kind_t op_kind_i;
    mem_size_t op_size_i;
    logic      op_signed_i;
    word_t     op_addr_i;
    word_t     op_wdata_i;
    reg_addr_t op_rd_i;
    logic      op_we_i;
    logic      op_ready_o;
    logic      mem_req_valid_o;
    bus_cmd_t  mem_req_cmd_o;
    bus_addr_t mem_req_addr_o;
    byte_t     mem_req_wdata_o;
    logic      mem_req_ready_i;
    logic      mem_resp_valid_i;
    byte_t     mem_resp_data_i;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;
    logic      wb_ready_i;

    op_row_t   table_q [NROWS];
    byte_t     shadow [256];
    bus_addr_t exp_addr_q [$];
    bus_cmd_t  exp_cmd_q [$];
    byte_t     exp_wdata_q [$];
    int        errors;
    int        failed;
    int        cycles;

    mem_stage_top UUT (.*);

    byte_mem_model u_mem (
        .clk          (clk),
        .req_valid_i  (mem_req_valid_o),
        .req_cmd_i    (mem_req_cmd_o),
        .req_addr_i   (mem_req_addr_o),
        .req_wdata_i  (mem_req_wdata_o),
        .req_ready_o  (mem_req_ready_i),
        .resp_valid_o (mem_resp_valid_i),
        .resp_data_o  (mem_resp_data_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int size_bytes(mem_size_t size);
        return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    endfunction

    // Little-endian bytes from the shadow with fill from the top loaded byte
    function automatic word_t expected_load(word_t addr, mem_size_t size, logic sgn);
        int   n;
        word_t v;
        n = size_bytes(size);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = shadow[addr[7:0] + 8'(k)];
        end
        if (sgn && v[8*n-1]) begin
            for (int b = 8 * n; b < 32; b++) begin
                v[b] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        assert (exp === act) else begin
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cond(logic ok, string what);
        assert (ok) else begin
            $display("Error at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    // Byte requests in issue order, checked at the handshake edge
    always @(posedge clk) begin
        bus_cmd_t exp_cmd;
        byte_t    exp_wdata;
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (exp_addr_q.size() == 0) begin
                check_cond(1'b0, "memory request issued with none expected");
            end else begin
                exp_cmd   = exp_cmd_q.pop_front();
                exp_wdata = exp_wdata_q.pop_front();
                check_word("mem_req_addr_o", exp_addr_q.pop_front(), mem_req_addr_o);
                check_word("mem_req_cmd_o", word_t'(exp_cmd), word_t'(mem_req_cmd_o));
                if (exp_cmd == BUS_WRITE) begin
                    check_word("mem_req_wdata_o", word_t'(exp_wdata),
                               word_t'(mem_req_wdata_o));
                end
            end
        end
    end

    task automatic set_row(int i, mem_kind_t kind, mem_size_t size, logic sgn, word_t addr,
                           word_t wdata, reg_addr_t rd, logic we, logic [1:0] mode,
                           logic [3:0] hold);
        table_q[i] = '{kind, size, sgn, addr, wdata, rd, we, mode, hold};
    endtask

    task automatic run_row(int i);
        op_row_t   r;
        word_t     exp_data;
        word_t     held_data;
        reg_addr_t held_rd;
        r = table_q[i];
        exp_data = (r.mode == M_LOAD) ? expected_load(r.addr, r.size, r.sgn) : r.addr;
        if (r.kind != MEM_ALU) begin
            for (int k = 0; k < size_bytes(r.size); k++) begin
                exp_addr_q.push_back(r.addr + word_t'(k));
                exp_cmd_q.push_back((r.kind == MEM_STORE) ? BUS_WRITE : BUS_READ);
                exp_wdata_q.push_back(r.wdata[8*k +: 8]);
            end
        end
        if (r.kind == MEM_STORE) begin
            for (int k = 0; k < size_bytes(r.size); k++) begin
                shadow[r.addr[7:0] + 8'(k)] = r.wdata[8*k +: 8];
            end
        end

        @(negedge clk);
        op_valid_i  = 1'b1;
        op_kind_i   = r.kind;
        op_size_i   = r.size;
        op_signed_i = r.sgn;
        op_addr_i   = r.addr;
        op_wdata_i  = r.wdata;
        op_rd_i     = r.rd;
        op_we_i     = r.we;
        wb_ready_i  = (r.hold == 0);
        while (!op_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        op_valid_i = 1'b0;

        if (r.mode == M_NONE) begin
            while (!op_ready_o) begin
                check_cond(!wb_valid_o, "writeback raised for an operation without one");
                @(negedge clk);
            end
            check_cond(!wb_valid_o, "writeback raised for an operation without one");
        end else begin
            while (!wb_valid_o) begin
                check_cond(!op_ready_o, "op_ready_o high before writeback");
                @(negedge clk);
            end
            held_rd   = wb_rd_o;
            held_data = wb_data_o;
            // Writeback held back by the consumer
            repeat (r.hold) begin
                @(negedge clk);
                check_cond(wb_valid_o, "wb_valid_o dropped while stalled");
                check_word("wb_rd_o", word_t'(held_rd), word_t'(wb_rd_o));
                check_word("wb_data_o", held_data, wb_data_o);
                check_cond(!op_ready_o, "op_ready_o high while writeback stalled");
            end
            wb_ready_i = 1'b1;
            check_word("wb_rd_o", word_t'(r.rd), word_t'(wb_rd_o));
            check_word("wb_data_o", exp_data, wb_data_o);
        end
        check_cond(exp_addr_q.size() == 0, "fewer memory requests than expected");
    endtask

    initial begin
        int errors_before;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        op_valid_i  = 1'b0;
        op_kind_i   = MEM_ALU;
        op_size_i   = SIZE_BYTE;
        op_signed_i = 1'b0;
        op_addr_i   = '0;
        op_wdata_i  = '0;
        op_rd_i     = '0;
        op_we_i     = 1'b0;
        wb_ready_i  = 1'b1;
        errors      = 0;
        failed      = 0;
        cycles      = 0;

        set_row(0,  MEM_ALU,   SIZE_WORD, 0, 32'h1234_5678, 32'h0,         5'd3,  1, M_ALU,  0);
        set_row(1,  MEM_ALU,   SIZE_WORD, 0, 32'hcafe_0001, 32'h0,         5'd4,  0, M_NONE, 0);
        set_row(2,  MEM_LOAD,  SIZE_BYTE, 0, 32'h0000_0010, 32'h0,         5'd5,  1, M_LOAD, 0);
        set_row(3,  MEM_LOAD,  SIZE_BYTE, 1, 32'h0000_0011, 32'h0,         5'd6,  1, M_LOAD, 0);
        set_row(4,  MEM_LOAD,  SIZE_HALF, 0, 32'h0000_0020, 32'h0,         5'd7,  1, M_LOAD, 0);
        set_row(5,  MEM_LOAD,  SIZE_HALF, 1, 32'h0000_0022, 32'h0,         5'd8,  1, M_LOAD, 1);
        set_row(6,  MEM_LOAD,  SIZE_WORD, 0, 32'h0000_0030, 32'h0,         5'd9,  1, M_LOAD, 0);
        set_row(7,  MEM_STORE, SIZE_BYTE, 0, 32'h0000_0040, 32'h0000_00a5, 5'd0,  0, M_NONE, 0);
        set_row(8,  MEM_STORE, SIZE_HALF, 0, 32'h0000_0050, 32'h0000_8421, 5'd0,  0, M_NONE, 0);
        set_row(9,  MEM_STORE, SIZE_WORD, 0, 32'h0000_0060, 32'hdead_beef, 5'd0,  0, M_NONE, 0);
        set_row(10, MEM_LOAD,  SIZE_WORD, 0, 32'h0000_0040, 32'h0,         5'd10, 1, M_LOAD, 0);
        set_row(11, MEM_LOAD,  SIZE_WORD, 0, 32'h0000_0050, 32'h0,         5'd11, 1, M_LOAD, 2);
        set_row(12, MEM_LOAD,  SIZE_WORD, 1, 32'h0000_0060, 32'h0,         5'd12, 1, M_LOAD, 3);
        set_row(13, MEM_LOAD,  SIZE_HALF, 1, 32'h0000_0061, 32'h0,         5'd13, 1, M_LOAD, 2);
        set_row(14, MEM_ALU,   SIZE_WORD, 0, 32'h8000_00ff, 32'h0,         5'd31, 1, M_ALU,  4);
        set_row(15, MEM_LOAD,  SIZE_BYTE, 1, 32'h0000_0040, 32'h0,         5'd1,  1, M_LOAD, 0);
        set_row(16, MEM_LOAD,  SIZE_HALF, 0, 32'h0000_0062, 32'h0,         5'd14, 1, M_LOAD, 0);

        // Memory model fills itself at time zero
        #1;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = u_mem.mem[a];
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_cond(op_ready_o, "op_ready_o low after reset");
        check_cond(!wb_valid_o, "wb_valid_o high after reset");
        check_cond(!mem_req_valid_o, "mem_req_valid_o high after reset");

        for (int i = 0; i < NROWS; i++) begin
            errors_before = errors;
            run_row(i);
            if (errors == errors_before) begin
                $display("Test %0d: ok", i);
            end else begin
                $display("Test %0d: FAILED", i);
                failed++;
            end
        end

        $display("Tests run %0d, failed %0d, errors %0d", NROWS, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/mem_op_pkg.sv
source/mem_bus_pkg.sv
source/mem_access_seq.sv
source/wb_result_builder.sv
source/mem_stage_top.sv
sim/byte_mem_model.sv
sim/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_stage -f all.f -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
